/* hdl/big_core_pkg.sv */
package big_core_pkg;

    // ====================
    // Data path width
    // ====================
    localparam int XLEN = 32;

    // ====================
    // Instruction fields
    // ====================
    localparam int RD_LSB     = 7;   // rd  [11:7]
    localparam int FUNCT3_LSB = 12;  // funct3 [14:12]
    localparam int RS1_LSB    = 15;  // rs1 [19:15]
    localparam int RS2_LSB    = 20;  // rs2 [24:20]
    localparam int FUNCT7_LSB = 25;  // funct7 [31:25]
    localparam int F7_SUB_BIT = 5;   // funct7 bit that turns ADD into SUB

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,  // R-type ALU
        OPC_OP_IMM = 7'b0010011,  // I-type ALU
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcodeE;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B   // LUI passes the immediate through
    } aluOpE;

    typedef enum logic {
        MEM_BYTE = 1'b0,
        MEM_WORD = 1'b1
    } memWidthE;

    // ALU funct3 codes, shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Branch conditions
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // Load/store width, anything else is taken as a word
    localparam logic [2:0] F3_BYTE = 3'b000;  // LB / SB

endpackage

/* hdl/core_alu.sv */
`timescale 1ns/1ps

module core_alu (
    input  big_core_pkg::aluOpE            op,
    input  logic [big_core_pkg::XLEN-1:0]  a,
    input  logic [big_core_pkg::XLEN-1:0]  b,
    output logic [big_core_pkg::XLEN-1:0]  result,
    output logic                           zero
);

    import big_core_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;  // Also drives branch compare
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLT: begin
                result = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            ALU_PASS_B: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Equal operands give zero after SUB
    assign zero = (result == '0);

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                           Clk,
    input  logic                           arstN,
    input  logic [4:0]                     rs1,
    input  logic [4:0]                     rs2,
    input  logic [4:0]                     rd,
    input  logic                           wrEn,
    input  logic [big_core_pkg::XLEN-1:0]  wrData,
    output logic [big_core_pkg::XLEN-1:0]  rs1Data,
    output logic [big_core_pkg::XLEN-1:0]  rs2Data
);

    import big_core_pkg::*;

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (rd != 5'd0)) begin
            regs[rd] <= wrData;  // x0 never written, stays zero
        end
    end

    // Combinational read ports
    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

endmodule

/* hdl/byte_mem.sv */
`timescale 1ns/1ps

module byte_mem #(
    parameter int MEM_SIZE   = 1024,  // Bytes, power of two
    parameter int MEM_OFFSET = 0      // Byte address of mem[0]
) (
    input  logic        Clk,
    input  logic [31:0] address,
    input  logic        wrEn,
    input  logic [3:0]  byteEn,
    input  logic [31:0] wrData,
    output logic [31:0] rdData
);

    localparam int ADDR_W = $clog2(MEM_SIZE);

    logic [7:0]        mem [MEM_SIZE];
    logic [31:0]       offset;
    logic [ADDR_W-1:0] laneIdx [4];
    logic [32:0]       topByte;

    assign offset = address - 32'(MEM_OFFSET);

    // Lane k sits at address+k, little endian
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            laneIdx[k] = ADDR_W'(offset + 32'(k));
        end
    end

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rdData[8*k +: 8] = mem[laneIdx[k]];
        end
    end

    always_ff @(posedge Clk) begin
        if (wrEn) begin
            for (int k = 0; k < 4; k++) begin
                if (byteEn[k]) begin
                    mem[laneIdx[k]] <= wrData[8*k +: 8];
                end
            end
        end
    end

    // Highest byte touched by the current write
    assign topByte = {1'b0, address} + (byteEn[3] ? 33'd3 : 33'd0);

    // Writes must land fully inside this memory
    assert property (@(posedge Clk) wrEn |->
        (address >= 32'(MEM_OFFSET)) && (topByte < 33'(MEM_OFFSET + MEM_SIZE)));

    // Only byte and word accesses exist
    assert property (@(posedge Clk) wrEn |-> (byteEn == 4'b0001) || (byteEn == 4'b1111));

endmodule

/* hdl/sc_core.sv */
`timescale 1ns/1ps

module sc_core (
    input  logic                           Clk,
    input  logic                           arstN,
    input  logic [31:0]                    Instruction,
    input  logic [big_core_pkg::XLEN-1:0]  DMemRspData,
    output logic [31:0]                    Pc,
    output logic [big_core_pkg::XLEN-1:0]  DMemAddress,
    output logic [big_core_pkg::XLEN-1:0]  DMemData,
    output logic [3:0]                     DMemByteEn,
    output logic                           DMemWrEn,
    output logic                           DMemRdEn
);

    import big_core_pkg::*;

    opcodeE          opcode;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] immI;
    logic [XLEN-1:0] immS;
    logic [XLEN-1:0] immB;
    logic [XLEN-1:0] immU;
    logic [XLEN-1:0] immJ;
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic [XLEN-1:0] aluB;
    logic [XLEN-1:0] aluResult;
    logic            aluZero;
    aluOpE           aluOp;
    memWidthE        memWidth;
    logic            regWrEn;
    logic            isLoad;
    logic            isStore;
    logic            isBranch;
    logic            isJal;
    logic            branchTaken;
    logic [XLEN-1:0] loadData;
    logic [XLEN-1:0] wbData;
    logic [31:0]     pcPlus4;
    logic [31:0]     pcTarget;
    logic [31:0]     nextPc;

    function automatic aluOpE arithOp(input logic [2:0] f3, input logic subSel);
        case (f3)
            F3_ADD_SUB: arithOp = subSel ? ALU_SUB : ALU_ADD;
            F3_SLT:     arithOp = ALU_SLT;
            F3_XOR:     arithOp = ALU_XOR;
            F3_OR:      arithOp = ALU_OR;
            F3_AND:     arithOp = ALU_AND;
            default:    arithOp = ALU_ADD;
        endcase
    endfunction

    // ====================
    // Decode
    // ====================
    assign opcode = opcodeE'(Instruction[6:0]);
    assign rd     = Instruction[RD_LSB +: 5];
    assign funct3 = Instruction[FUNCT3_LSB +: 3];
    assign rs1    = Instruction[RS1_LSB +: 5];
    assign rs2    = Instruction[RS2_LSB +: 5];
    assign funct7 = Instruction[FUNCT7_LSB +: 7];

    assign immI = {{(XLEN-12){Instruction[31]}}, Instruction[31:20]};
    assign immS = {{(XLEN-12){Instruction[31]}}, Instruction[31:25], Instruction[11:7]};
    assign immB = {{(XLEN-13){Instruction[31]}}, Instruction[31], Instruction[7],
                   Instruction[30:25], Instruction[11:8], 1'b0};
    assign immU = {Instruction[31:12], 12'b0};
    assign immJ = {{(XLEN-21){Instruction[31]}}, Instruction[31], Instruction[19:12],
                   Instruction[20], Instruction[30:21], 1'b0};

    always_comb begin
        aluOp    = ALU_ADD;
        aluB     = immI;
        regWrEn  = 1'b0;
        isLoad   = 1'b0;
        isStore  = 1'b0;
        isBranch = 1'b0;
        isJal    = 1'b0;
        case (opcode)
            OPC_OP: begin
                aluOp   = arithOp(funct3, funct7[F7_SUB_BIT]);
                aluB    = rs2Data;
                regWrEn = 1'b1;
            end
            OPC_OP_IMM: begin
                aluOp   = arithOp(funct3, 1'b0);  // No SUBI
                regWrEn = 1'b1;
            end
            OPC_LUI: begin
                aluOp   = ALU_PASS_B;
                aluB    = immU;
                regWrEn = 1'b1;
            end
            OPC_LOAD: begin
                isLoad  = 1'b1;
                regWrEn = 1'b1;
            end
            OPC_STORE: begin
                aluB    = immS;
                isStore = 1'b1;
            end
            OPC_BRANCH: begin
                aluOp    = ALU_SUB;
                aluB     = rs2Data;
                isBranch = 1'b1;
            end
            OPC_JAL: begin
                isJal   = 1'b1;
                regWrEn = 1'b1;
            end
            default: begin
                regWrEn = 1'b0;  // Unsupported, acts as NOP
            end
        endcase
    end

    reg_file regFile (
        .Clk     (Clk),
        .arstN   (arstN),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .wrEn    (regWrEn),
        .wrData  (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    core_alu alu (
        .op     (aluOp),
        .a      (rs1Data),
        .b      (aluB),
        .result (aluResult),
        .zero   (aluZero)
    );

    // ====================
    // Data memory
    // ====================
    assign memWidth    = (funct3 == F3_BYTE) ? MEM_BYTE : MEM_WORD;
    assign DMemAddress = aluResult;
    assign DMemWrEn    = isStore && arstN;  // Strobes stay low under reset
    assign DMemRdEn    = isLoad && arstN;
    assign DMemByteEn  = (memWidth == MEM_BYTE) ? 4'b0001 : 4'b1111;
    assign DMemData    = (memWidth == MEM_BYTE) ? {{(XLEN-8){1'b0}}, rs2Data[7:0]}
                                                : rs2Data;  // SB byte rides in lane 0

    // LB sign-extends lane 0
    assign loadData = (memWidth == MEM_BYTE) ? {{(XLEN-8){DMemRspData[7]}}, DMemRspData[7:0]}
                                             : DMemRspData;

    assign wbData = isLoad ? loadData :
                    isJal  ? pcPlus4  : aluResult;

    // ====================
    // Next PC
    // ====================
    always_comb begin
        case (funct3)
            F3_BEQ:  branchTaken = isBranch && aluZero;
            F3_BNE:  branchTaken = isBranch && !aluZero;
            default: branchTaken = 1'b0;
        endcase
    end

    assign pcPlus4  = Pc + 32'd4;
    assign pcTarget = Pc + (isJal ? immJ : immB);
    assign nextPc   = (isJal || branchTaken) ? pcTarget : pcPlus4;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            Pc <= '0;
        end else begin
            Pc <= nextPc;  // One instruction per cycle
        end
    end

    // Branch and jump offsets must keep the PC word aligned
    assert property (@(posedge Clk) disable iff (!arstN) Pc[1:0] == 2'b00);

endmodule

/* hdl/ref_core.sv */
`timescale 1ns/1ps

module ref_core #(
    parameter int I_MEM_MSB    = 1023,  // Top byte of instruction memory
    parameter int D_MEM_SIZE   = 1024,
    parameter int D_MEM_OFFSET = 4096
) (
    input  logic        Clk,
    input  logic        arstN,
    input  logic        loadEn,
    input  logic [31:0] loadAddress,
    input  logic [31:0] loadData,
    output logic [31:0] Pc,
    output logic        DMemWrEn,
    output logic [31:0] DMemAddress,
    output logic [31:0] DMemData,
    output logic [3:0]  DMemByteEn
);

    logic [31:0] Instruction;
    logic [31:0] DMemRspData;

    sc_core scCore (
        .Clk         (Clk),
        .arstN       (arstN),
        .Instruction (Instruction),  // From I-mem
        .DMemRspData (DMemRspData),  // From D-mem
        .Pc          (Pc),
        .DMemAddress (DMemAddress),
        .DMemData    (DMemData),
        .DMemByteEn  (DMemByteEn),
        .DMemWrEn    (DMemWrEn),
        .DMemRdEn    ()               // Reads are combinational, strobe not needed
    );

    // ====================
    // Instruction memory
    // ====================
    byte_mem #(
        .MEM_SIZE   (I_MEM_MSB + 1),
        .MEM_OFFSET (0)
    ) iMem (
        .Clk     (Clk),
        .address (arstN ? Pc : loadAddress),  // Load port owns it during reset
        .wrEn    (loadEn && !arstN),
        .byteEn  (4'b1111),
        .wrData  (loadData),
        .rdData  (Instruction)
    );

    // ====================
    // Data memory
    // ====================
    byte_mem #(
        .MEM_SIZE   (D_MEM_SIZE),
        .MEM_OFFSET (D_MEM_OFFSET)
    ) dMem (
        .Clk     (Clk),
        .address (DMemAddress),
        .wrEn    (DMemWrEn),
        .byteEn  (DMemByteEn),
        .wrData  (DMemData),
        .rdData  (DMemRspData)
    );

endmodule

/* sim/store_checker.sv */
`timescale 1ns/1ps

module store_checker #(
    parameter int GOLDEN_DEPTH = 256
) (
    input  logic        Clk,
    input  logic        arstN,
    input  logic        DMemWrEn,
    input  logic [31:0] DMemAddress,
    input  logic [31:0] DMemData,
    input  logic [3:0]  DMemByteEn,
    input  logic [31:0] golden [GOLDEN_DEPTH]
);

    int          storeIdx   = 0;  // Next expected record
    int          mismatches = 0;
    int          extras     = 0;
    int          recBase;
    logic [31:0] laneMask;        // Data lanes covered by the expected byteEn

    // Store count sits right after the program words
    function automatic int expectedStores();
        return int'(golden[int'(golden[0]) + 1]);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL time %0t %s expected %h actual %h", $time, name, expected, actual);
            mismatches++;
        end
    endtask

    // Outputs are stable at the edge that ends the store cycle
    always @(posedge Clk) begin
        if (arstN && DMemWrEn) begin
            if (storeIdx >= expectedStores()) begin
                $display("Unexpected extra store at time %0t to address %h, only %0d expected",
                         $time, DMemAddress, expectedStores());
                extras++;
            end else begin
                recBase = int'(golden[0]) + 2 + 3 * storeIdx;
                for (int k = 0; k < 4; k++) begin
                    laneMask[8*k +: 8] = {8{golden[recBase + 2][k]}};
                end
                checkValue("DMemAddress", golden[recBase], DMemAddress);
                checkValue("DMemByteEn", {28'b0, golden[recBase + 2][3:0]}, {28'b0, DMemByteEn});
                checkValue("DMemData", golden[recBase + 1] & laneMask, DMemData & laneMask);
            end
            storeIdx++;
        end
    end

    task automatic finalReport(output int mismatchCount, output int extraCount,
                               output int missingCount);
        missingCount = 0;
        if (storeIdx < expectedStores()) begin
            missingCount = expectedStores() - storeIdx;
            $display("Missing stores, only %0d of %0d expected stores were seen",
                     storeIdx, expectedStores());
        end
        mismatchCount = mismatches;
        extraCount    = extras;
    endtask

endmodule

/* sim/ref_core_tb.sv */
`timescale 1ns/1ps

module ref_core_tb;

    localparam int GOLDEN_DEPTH = 256;
    localparam int CLK_PERIOD   = 8;   // ns

    logic        Clk;
    logic        arstN;
    logic        loadEn;
    logic [31:0] loadAddress;
    logic [31:0] loadData;
    logic [31:0] Pc;
    logic        DMemWrEn;
    logic [31:0] DMemAddress;
    logic [31:0] DMemData;
    logic [3:0]  DMemByteEn;
    logic [31:0] golden [GOLDEN_DEPTH];
    int          wordCount;
    int          storeCount;
    int          mismatches;
    int          extras;
    int          missing;

    ref_core #(
        .I_MEM_MSB    (1023),
        .D_MEM_SIZE   (1024),
        .D_MEM_OFFSET (4096)
    ) UUT (
        .Clk         (Clk),
        .arstN       (arstN),
        .loadEn      (loadEn),
        .loadAddress (loadAddress),
        .loadData    (loadData),
        .Pc          (Pc),
        .DMemWrEn    (DMemWrEn),
        .DMemAddress (DMemAddress),
        .DMemData    (DMemData),
        .DMemByteEn  (DMemByteEn)
    );

    store_checker #(
        .GOLDEN_DEPTH (GOLDEN_DEPTH)
    ) storeCheck (
        .Clk         (Clk),
        .arstN       (arstN),
        .DMemWrEn    (DMemWrEn),
        .DMemAddress (DMemAddress),
        .DMemData    (DMemData),
        .DMemByteEn  (DMemByteEn),
        .golden      (golden)
    );

    initial begin
        Clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) Clk = ~Clk;
        end
    end

    // ====================
    // Program load
    // ====================
    task automatic loadProgram();
        for (int i = 0; i < wordCount; i++) begin
            @(posedge Clk);
            loadEn      <= 1'b1;
            loadAddress <= 32'(4 * i);
            loadData    <= golden[1 + i];
        end
        @(posedge Clk);
        loadEn      <= 1'b0;
        loadAddress <= '0;  // Load port back to idle
        loadData    <= '0;
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        arstN       = 1'b0;
        loadEn      = 1'b0;
        loadAddress = '0;
        loadData    = '0;
        $readmemh("sim/program_golden.hex", golden);
        if ($isunknown(golden[0])) begin
            $display("The golden file sim/program_golden.hex could not be read");
            $display("Finished with errors");
            $finish;
        end else begin
            wordCount  = int'(golden[0]);
            storeCount = int'(golden[wordCount + 1]);
            loadProgram();
            repeat (10) @(posedge Clk);  // Reset held 10 more cycles after the load
            arstN <= 1'b1;
            // Last word is a jump to itself
            do begin
                @(posedge Clk);
            end while (Pc != 32'(4 * (wordCount - 1)));
            repeat (2) @(posedge Clk);
            storeCheck.finalReport(mismatches, extras, missing);
            $display("Errors %0d total, %0d mismatches, %0d extra stores, %0d missing stores",
                     mismatches + extras + missing, mismatches, extras, missing);
            if (mismatches + extras + missing == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

    // Watchdog, sized from program and store counts
    initial begin
        wait (arstN === 1'b1);
        #((wordCount + storeCount + 50) * CLK_PERIOD);
        $display("Timeout, the program did not reach its final jump in time");
        $display("Finished with errors");
        $finish;
    end

endmodule

/* sim/program_golden.hex */
// Word count, program words, store count, then one store record per line
// Store record columns are address, data, byteEn
00000029
000010b7 // lui  x1, 0x1
01900113 // addi x2, x0, 25
ffa00193 // addi x3, x0, -6
00310233 // add  x4, x2, x3
0040a023 // sw   x4, 0(x1)
402182b3 // sub  x5, x3, x2
0050a223 // sw   x5, 4(x1)
00317333 // and  x6, x2, x3
0060a423 // sw   x6, 8(x1)
003163b3 // or   x7, x2, x3
0070a623 // sw   x7, 12(x1)
00314433 // xor  x8, x2, x3
0080a823 // sw   x8, 16(x1)
0021a4b3 // slt  x9, x3, x2
0090aa23 // sw   x9, 20(x1)
0f01f513 // andi x10, x3, 0xf0
70356513 // ori  x10, x10, 0x703
fff54513 // xori x10, x10, -1
0011a593 // slti x11, x3, 1
00b50533 // add  x10, x10, x11
00a0ac23 // sw   x10, 24(x1)
12345637 // lui  x12, 0x12345
cde60613 // addi x12, x12, -0x322
00c0ae23 // sw   x12, 28(x1)
02c08023 // sb   x12, 32(x1)
02008683 // lb   x13, 32(x1)
02d0a223 // sw   x13, 36(x1)
00210463 // beq  x2, x2, +8 taken
0220a423 // sw   x2, 40(x1) skipped
00311463 // bne  x2, x3, +8 taken
0230a623 // sw   x3, 44(x1) skipped
00310463 // beq  x2, x3, +8 not taken
0220a823 // sw   x2, 48(x1)
00211463 // bne  x2, x2, +8 not taken
0230aa23 // sw   x3, 52(x1)
0080076f // jal  x14, +8
0220ac23 // sw   x2, 56(x1) skipped
02e0ae23 // sw   x14, 60(x1)
06300013 // addi x0, x0, 99
0400a023 // sw   x0, 64(x1)
0000006f // jal  x0, 0
0000000e
00001000 00000013 f // add
00001004 ffffffe1 f // sub
00001008 00000018 f // and
0000100c fffffffb f // or
00001010 ffffffe3 f // xor
00001014 00000001 f // slt
00001018 fffff80d f // andi, ori, xori, slti
0000101c 12344cde f // lui plus addi
00001020 000000de 1 // sb
00001024 ffffffde f // lb sign-extended
00001030 00000019 f // after beq not taken
00001034 fffffffa f // after bne not taken
0000103c 00000090 f // jal link
00001040 00000000 f // x0 stays zero

/* vlog.f */
hdl/big_core_pkg.sv
hdl/core_alu.sv
hdl/reg_file.sv
hdl/byte_mem.sv
hdl/sc_core.sv
hdl/ref_core.sv
sim/store_checker.sv
sim/ref_core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ref_core testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ref_core_tb \
    -f vlog.f --Mdir obj_dir -o ref_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

OUTPUT=$(./obj_dir/ref_core_sim)
STATUS=$?
echo "$OUTPUT"
if [ $STATUS -ne 0 ]; then
    echo "Simulation exited with status $STATUS"
    exit 1
fi

if echo "$OUTPUT" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
